// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
LINTFLAGS = --lint-only --timing -Wall
TOP       = fp16MulUnitTb
FILELIST  = fp16MulUnit.f
PASS_MSG  = NO ERRORS
BIN       = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output is kept in a shell variable, the status comes from grep
run: build
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: fp16MulUnit.f
logic/fp16Pkg.sv
logic/fpStageIf.sv
logic/fpMulCtrl.sv
logic/fpMulPrep.sv
logic/fpMulNormRound.sv
logic/fp16MulUnit.sv
test/fp16MulUnit_checker.sv
test/fp16MulUnitTb.sv

// File: logic/fp16MulUnit.sv
`timescale 1ns/1ns

module fp16MulUnit import fp16Pkg::*; #(
	parameter int QUEUE_DEPTH = 4  // Power of two, 2 to 8
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [4:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic              launch;
	logic [DATA_W-1:0] opA;
	logic [DATA_W-1:0] opB;
	logic              resValid;
	logic [DATA_W-1:0] result;
	logic [FLAG_W-1:0] flags;

	fpStageIf stage ();  // Stage 1 -> stage 2

	fpMulCtrl #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) ctrl (
		.clk      (clk),
		.rst      (rst),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.resValid (resValid),
		.result   (result),
		.flags    (flags),
		.launch   (launch),
		.opA      (opA),
		.opB      (opB)
	);

	fpMulPrep prep (
		.clk    (clk),
		.rst    (rst),
		.launch (launch),
		.opA    (opA),
		.opB    (opB),
		.st     (stage.prep)
	);

	fpMulNormRound normRound (
		.clk      (clk),
		.rst      (rst),
		.st       (stage.round),
		.resValid (resValid),
		.result   (result),
		.flags    (flags)
	);

endmodule

// File: logic/fp16Pkg.sv
package fp16Pkg;

	// binary16 field layout
	localparam int EXP_W    = 5;
	localparam int FRAC_W   = 10;
	localparam int DATA_W   = 16;
	localparam int EXP_BIAS = 15;

	localparam int SIG_W  = FRAC_W + 1;  // Significand with hidden bit
	localparam int PROD_W = 2 * SIG_W;   // Full significand product
	localparam int EXPS_W = EXP_W + 2;   // Signed exponent, room for over/underrun

	localparam int EXP_MAX = (1 << EXP_W) - 2;  // Largest finite biased exponent

	// Exception flag vector
	localparam int FLAG_W         = 5;
	localparam int FLAG_INVALID   = 4;
	localparam int FLAG_OVERFLOW  = 3;
	localparam int FLAG_UNDERFLOW = 2;
	localparam int FLAG_INEXACT   = 1;
	localparam int FLAG_NAN_IN    = 0;

	localparam logic [DATA_W-1:0] QNAN = 16'h7e00;

	// APB register map
	typedef enum logic [4:0] {
		REG_OPA    = 5'h00,
		REG_OPB    = 5'h04,
		REG_CMD    = 5'h08,
		REG_STATUS = 5'h0C,
		REG_RESULT = 5'h10
	} regAddr_t;

	// APB transfer phases
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apbState_t;

endpackage

// File: logic/fpMulCtrl.sv
`timescale 1ns/1ns

module fpMulCtrl import fp16Pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [4:0]        paddr,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	input  logic              resValid,
	input  logic [DATA_W-1:0] result,
	input  logic [FLAG_W-1:0] flags,
	output logic              launch,
	output logic [DATA_W-1:0] opA,
	output logic [DATA_W-1:0] opB
);

	localparam int PTR_W   = $clog2(QUEUE_DEPTH);
	localparam int CNT_W   = PTR_W + 1;
	localparam int ENTRY_W = FLAG_W + DATA_W;

	apbState_t apbState;
	apbState_t apbNext;
	logic      access;

	logic wrOpA;
	logic wrOpB;
	logic launchReq;
	logic popReq;

	logic [ENTRY_W-1:0] queueMem [QUEUE_DEPTH];  // {flags, result}
	logic [PTR_W-1:0]   wrPtr;
	logic [PTR_W-1:0]   rdPtr;
	logic [CNT_W-1:0]   count;     // Results stored
	logic [CNT_W-1:0]   inFlight;  // Launched, not yet stored
	logic [CNT_W:0]     reserved;
	logic               hasRoom;
	logic               full;
	logic [3:0]         statusCnt;

	assign pready = 1'b1;  // Zero wait states

	// Phase tracker
	always_comb begin
		if (!psel)
			apbNext = APB_IDLE;
		else if (!penable)
			apbNext = APB_SETUP;
		else
			apbNext = APB_ACCESS;
	end

	always_ff @(posedge clk) begin
		if (rst)
			apbState <= APB_IDLE;
		else
			apbState <= apbNext;
	end

	// Access only counts after a setup cycle
	assign access = psel & penable & (apbState == APB_SETUP);

	// Every slot is either stored or promised to an in-flight launch
	assign reserved  = {1'b0, count} + {1'b0, inFlight};
	assign hasRoom   = reserved < (CNT_W + 1)'(QUEUE_DEPTH);
	assign full      = count == CNT_W'(QUEUE_DEPTH);
	assign statusCnt = 4'(count);

	// Register decode, read mux and error response
	always_comb begin
		wrOpA     = 1'b0;
		wrOpB     = 1'b0;
		launchReq = 1'b0;
		popReq    = 1'b0;
		prdata    = '0;
		pslverr   = 1'b0;
		if (access) begin
			case (regAddr_t'(paddr))
				REG_OPA: begin
					if (pwrite)
						wrOpA = 1'b1;
					else
						prdata = 32'(opA);
				end
				REG_OPB: begin
					if (pwrite)
						wrOpB = 1'b1;
					else
						prdata = 32'(opB);
				end
				REG_CMD: begin
					if (pwrite && pwdata[0]) begin
						if (hasRoom)
							launchReq = 1'b1;
						else
							pslverr = 1'b1;  // Back-pressure, launch dropped
					end
				end
				REG_STATUS: begin
					if (pwrite)
						pslverr = 1'b1;  // Read only
					else
						prdata = {26'b0, inFlight != '0, full, statusCnt};
				end
				REG_RESULT: begin
					if (pwrite || count == '0) begin
						pslverr = 1'b1;  // Read only, or nothing to pop
					end else begin
						prdata = 32'(queueMem[rdPtr]);
						popReq = 1'b1;
					end
				end
				default: pslverr = 1'b1;  // Unmapped
			endcase
		end
	end

	// Operand registers and launch strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			opA    <= '0;
			opB    <= '0;
			launch <= 1'b0;
		end else begin
			if (wrOpA)
				opA <= pwdata[DATA_W-1:0];
			if (wrOpB)
				opB <= pwdata[DATA_W-1:0];
			launch <= launchReq;  // One cycle pulse into stage 1
		end
	end

	// Result storage, slot already reserved at launch
	always_ff @(posedge clk) begin
		if (resValid)
			queueMem[wrPtr] <= {flags, result};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			inFlight <= '0;
		end else begin
			if (resValid)
				wrPtr <= wrPtr + 1'b1;  // Wraps, depth is a power of two
			if (popReq)
				rdPtr <= rdPtr + 1'b1;
			count    <= count + CNT_W'(resValid) - CNT_W'(popReq);
			inFlight <= inFlight + CNT_W'(launchReq) - CNT_W'(resValid);
		end
	end

endmodule

// File: logic/fpMulNormRound.sv
`timescale 1ns/1ns

module fpMulNormRound import fp16Pkg::*; (
	input  logic              clk,
	input  logic              rst,
	fpStageIf.round           st,
	output logic              resValid,
	output logic [DATA_W-1:0] result,
	output logic [FLAG_W-1:0] flags
);

	logic [PROD_W-1:0]        norm;     // Leading one at the top
	logic [SIG_W-1:0]         sig;
	logic                     guard;
	logic                     sticky;
	logic                     roundUp;
	logic [SIG_W:0]           sigRnd;   // Extra bit catches carry out
	logic                     carry;
	logic [FRAC_W-1:0]        fracFinal;
	logic signed [EXPS_W-1:0] expNorm;
	logic signed [EXPS_W-1:0] expFinal;
	logic                     inexact;
	logic [DATA_W-1:0]        resNext;
	logic [FLAG_W-1:0]        flagsNext;

	// Product lies in [1,4) and a set top bit means [2,4)
	assign norm    = st.product[PROD_W-1] ? st.product : st.product << 1;
	assign expNorm = st.expSum + $signed({{(EXPS_W-1){1'b0}}, st.product[PROD_W-1]});

	assign sig    = norm[PROD_W-1 -: SIG_W];
	assign guard  = norm[PROD_W-1-SIG_W];
	assign sticky = |norm[PROD_W-2-SIG_W:0];

	// Nearest even
	assign roundUp = guard & (sticky | sig[0]);
	assign sigRnd  = {1'b0, sig} + (SIG_W + 1)'(roundUp);
	assign carry   = sigRnd[SIG_W];  // 1.111.. rounded up to 10.000..

	assign fracFinal = sigRnd[FRAC_W-1:0];  // Already zero after a carry out
	assign expFinal  = expNorm + $signed({{(EXPS_W-1){1'b0}}, carry});
	assign inexact   = guard | sticky;

	// Special cases ahead of range checks on the rounded exponent
	always_comb begin
		flagsNext = st.flagsIn;
		if (st.flagsIn[FLAG_INVALID]) begin
			resNext = QNAN;
		end else if (st.special) begin
			resNext = {st.sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};  // Inf times nonzero
		end else if (st.product == '0) begin
			resNext = {st.sign, {(DATA_W-1){1'b0}}};  // Exact zero without flags
		end else if (expFinal > EXPS_W'(EXP_MAX)) begin
			resNext = {st.sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
			flagsNext[FLAG_OVERFLOW] = 1'b1;
			flagsNext[FLAG_INEXACT]  = 1'b1;
		end else if (expFinal < EXPS_W'(1)) begin
			resNext = {st.sign, {(DATA_W-1){1'b0}}};  // No subnormal outputs
			flagsNext[FLAG_UNDERFLOW] = 1'b1;
			flagsNext[FLAG_INEXACT]   = 1'b1;
		end else begin
			resNext = {st.sign, expFinal[EXP_W-1:0], fracFinal};
			flagsNext[FLAG_INEXACT] = inexact;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			resValid <= 1'b0;
		else
			resValid <= st.valid;
	end

	always_ff @(posedge clk) begin
		if (st.valid) begin
			result <= resNext;
			flags  <= flagsNext;
		end
	end

endmodule

// File: logic/fpMulPrep.sv
`timescale 1ns/1ns

module fpMulPrep import fp16Pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              launch,
	input  logic [DATA_W-1:0] opA,
	input  logic [DATA_W-1:0] opB,
	fpStageIf.prep            st
);

	logic [EXP_W-1:0]  expA, expB;
	logic [FRAC_W-1:0] fracA, fracB;
	logic              zeroA, zeroB;  // Zero or subnormal
	logic              infA, infB;
	logic              nanA, nanB;
	logic [SIG_W-1:0]  sigA, sigB;
	logic              invalid;
	logic signed [EXPS_W-1:0] expSum;

	// Field split
	assign expA  = opA[DATA_W-2 -: EXP_W];
	assign expB  = opB[DATA_W-2 -: EXP_W];
	assign fracA = opA[FRAC_W-1:0];
	assign fracB = opB[FRAC_W-1:0];

	// Classification
	assign zeroA = expA == '0;  // Denormals flushed here
	assign zeroB = expB == '0;
	assign nanA  = (&expA) & (|fracA);
	assign nanB  = (&expB) & (|fracB);
	assign infA  = (&expA) & ~(|fracA);
	assign infB  = (&expB) & ~(|fracB);

	assign invalid = nanA | nanB | (infA & zeroB) | (infB & zeroA);

	// Hidden bit cleared for zero, so the product comes out zero
	assign sigA = zeroA ? '0 : {1'b1, fracA};
	assign sigB = zeroB ? '0 : {1'b1, fracB};

	// ea + eb - bias
	assign expSum = $signed({2'b00, expA}) + $signed({2'b00, expB})
		- EXPS_W'(EXP_BIAS);

	always_ff @(posedge clk) begin
		if (rst)
			st.valid <= 1'b0;
		else
			st.valid <= launch;
	end

	// Payload only loads on a launch
	always_ff @(posedge clk) begin
		if (launch) begin
			st.sign    <= opA[DATA_W-1] ^ opB[DATA_W-1];
			st.expSum  <= expSum;
			st.product <= sigA * sigB;  // 11x11 -> 22 bits
			st.special <= nanA | nanB | infA | infB;
			st.flagsIn <= '0;
			st.flagsIn[FLAG_INVALID] <= invalid;
			st.flagsIn[FLAG_NAN_IN]  <= nanA | nanB;
		end
	end

endmodule

// File: logic/fpStageIf.sv
`timescale 1ns/1ns

// Stage 1 to stage 2 pipeline register contents
interface fpStageIf import fp16Pkg::*; ();

	logic                     valid;
	logic                     sign;     // XOR of operand signs
	logic signed [EXPS_W-1:0] expSum;   // Biased product exponent, before normalize
	logic [PROD_W-1:0]        product;  // Zero when either operand is zero
	logic                     special;  // Result is NaN or infinity
	logic [FLAG_W-1:0]        flagsIn;  // Invalid and nan-in from classification

	modport prep (
		output valid,
		output sign,
		output expSum,
		output product,
		output special,
		output flagsIn
	);

	modport round (
		input valid,
		input sign,
		input expSum,
		input product,
		input special,
		input flagsIn
	);

endinterface

// File: test/fp16MulUnitTb.sv
`timescale 1ns/1ns

module fp16MulUnitTb import fp16Pkg::*; ();

	localparam int QUEUE_DEPTH = 4;
	localparam int TIMEOUT     = 40;  // Cycles or polls per wait

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [4:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	string       testName;

	fp16MulUnit #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) dut (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	always #4 clk = ~clk;  // 8 ns period

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "run aborted");
	endtask

	// Bound checker failures end the run
	always @(posedge clk)
		if (dut.chk.failures != 0)
			stopRun($sformatf("Bound assertion failed in %s", testName));

	task automatic checkResult(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
		if (act !== exp)
			stopRun($sformatf("ERR %s: result expected %h, actual %h", testName, exp, act));
	endtask

	task automatic checkFlags(input logic [FLAG_W-1:0] exp, input logic [FLAG_W-1:0] act);
		if (act !== exp)
			stopRun($sformatf("ERR %s: flags expected %b, actual %b", testName, exp, act));
	endtask

	task automatic checkErr(input logic exp, input logic act);
		if (act !== exp)
			stopRun($sformatf("ERR %s: pslverr expected %b, actual %b", testName, exp, act));
	endtask

	task automatic checkStatus(input logic [5:0] exp, input logic [5:0] act);
		if (act !== exp)
			stopRun($sformatf("ERR %s: status expected %h, actual %h", testName, exp, act));
	endtask

	// Reference product worked on the integer significands
	function automatic void refMul(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			output logic [DATA_W-1:0] res, output logic [FLAG_W-1:0] fl);
		int     ea;
		int     eb;
		int     e;
		int     shift;
		longint prod;
		longint sig;
		longint rem;
		longint half;
		logic   sgn;
		logic   nanIn;
		logic   infIn;
		logic   zeroIn;
		sgn    = a[15] ^ b[15];
		ea     = int'(a[14:10]);
		eb     = int'(b[14:10]);
		nanIn  = (ea == 31 && a[9:0] != 0) || (eb == 31 && b[9:0] != 0);
		infIn  = (ea == 31 && a[9:0] == 0) || (eb == 31 && b[9:0] == 0);
		zeroIn = ea == 0 || eb == 0;  // Subnormals count as zero
		fl = '0;
		fl[FLAG_NAN_IN] = nanIn;
		res = {sgn, 15'h0};
		if (nanIn || (infIn && zeroIn)) begin
			fl[FLAG_INVALID] = 1'b1;
			res = QNAN;
		end else if (infIn) begin
			res = {sgn, 15'h7c00};
		end else if (!zeroIn) begin
			prod  = longint'({1'b1, a[9:0]}) * longint'({1'b1, b[9:0]});  // Scaled by 2^20
			shift = prod >= (64'sd1 << 21) ? 11 : 10;
			e     = ea + eb - EXP_BIAS + shift - 10;
			sig   = prod >> shift;
			rem   = prod - (sig << shift);  // Discarded part
			half  = 64'sd1 << (shift - 1);
			if (rem > half || (rem == half && sig[0]))
				sig++;
			if (sig == 2048) begin
				sig = 1024;
				e++;
			end
			fl[FLAG_INEXACT] = rem != 0;
			if (e > 30) begin
				res = {sgn, 15'h7c00};
				fl[FLAG_OVERFLOW] = 1'b1;
				fl[FLAG_INEXACT]  = 1'b1;
			end else if (e < 1) begin
				fl[FLAG_UNDERFLOW] = 1'b1;
				fl[FLAG_INEXACT]   = 1'b1;
			end else begin
				res = {sgn, 5'(e), 10'(sig)};
			end
		end
	endfunction

	// One APB transfer as setup then access until pready
	task automatic apbAccess(input logic wr, input logic [4:0] addr, input logic [31:0] data,
			output logic [31:0] rdata, output logic err);
		int waits;
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waits   = 0;
		@(negedge clk);  // Mid-cycle where the response has settled
		while (!pready) begin
			if (waits == TIMEOUT)
				stopRun($sformatf("pready never rose in %s", testName));
			waits++;
			@(negedge clk);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apbWrite(input logic [4:0] addr, input logic [31:0] data, input logic expErr);
		logic [31:0] rdata;
		logic        err;
		apbAccess(1'b1, addr, data, rdata, err);
		checkErr(expErr, err);
	endtask

	task automatic apbRead(input logic [4:0] addr, output logic [31:0] data, input logic expErr);
		logic err;
		apbAccess(1'b0, addr, 32'h0, data, err);
		checkErr(expErr, err);
	endtask

	task automatic expectStatus(input logic [5:0] exp);
		logic [31:0] data;
		apbRead(REG_STATUS, data, 1'b0);
		checkStatus(exp, data[5:0]);
	endtask

	task automatic waitCount(input int n);
		logic [31:0] data;
		int          polls;
		polls = 0;
		data  = '0;
		while (data[3:0] != 4'(n)) begin
			if (polls == TIMEOUT)
				stopRun($sformatf("Queue never held %0d results in %s", n, testName));
			polls++;
			apbRead(REG_STATUS, data, 1'b0);
		end
	endtask

	task automatic launchPair(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			input logic expErr);
		apbWrite(REG_OPA, 32'(a), 1'b0);
		apbWrite(REG_OPB, 32'(b), 1'b0);
		apbWrite(REG_CMD, 32'h1, expErr);
	endtask

	task automatic popCheck(input logic [DATA_W-1:0] expRes, input logic [FLAG_W-1:0] expFl);
		logic [31:0] data;
		apbRead(REG_RESULT, data, 1'b0);
		checkResult(expRes, data[15:0]);
		checkFlags(expFl, data[20:16]);
	endtask

	task automatic expectProduct(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
			input logic [DATA_W-1:0] expRes, input logic [FLAG_W-1:0] expFl);
		launchPair(a, b, 1'b0);
		waitCount(1);
		popCheck(expRes, expFl);
	endtask

	task automatic applyReset();
		@(posedge clk);
		#1;
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic testBusErrors();
		logic [31:0] data;
		testName = "busErrors";
		expectStatus(6'h00);
		apbRead(5'h14, data, 1'b1);  // Unmapped
		apbWrite(REG_RESULT, 32'h0, 1'b1);
		apbWrite(REG_STATUS, 32'h0, 1'b1);
		apbRead(REG_RESULT, data, 1'b1);  // Empty queue
		checkResult(16'h0, data[15:0]);
		launchPair(16'h3c00, 16'h3c00, 1'b0);
		expectStatus(6'h20);  // One in flight and none stored yet
		waitCount(1);
		applyReset();  // Stored result must go away
		expectStatus(6'h00);
		apbRead(REG_RESULT, data, 1'b1);
	endtask

	task automatic testExact();
		testName = "exact";
		expectProduct(16'h3e00, 16'h4000, 16'h4200, 5'b00000);  // 1.5 * 2 = 3
		expectProduct(16'hbe00, 16'h4000, 16'hc200, 5'b00000);
		expectProduct(16'h3c00, 16'h5555, 16'h5555, 5'b00000);
		expectProduct(16'hc123, 16'h3c00, 16'hc123, 5'b00000);
	endtask

	task automatic testRange();
		testName = "range";
		expectProduct(16'h7bff, 16'h7bff, 16'h7c00, 5'b01010);  // Max finite squared
		expectProduct(16'h7bff, 16'hfbff, 16'hfc00, 5'b01010);
		expectProduct(16'h0400, 16'h0400, 16'h0000, 5'b00110);  // 2^-28
		expectProduct(16'h8400, 16'h0400, 16'h8000, 5'b00110);
		expectProduct(16'h0001, 16'h3c00, 16'h0000, 5'b00000);  // Subnormal in
		expectProduct(16'h83ff, 16'h4000, 16'h8000, 5'b00000);
	endtask

	task automatic testSpecial();
		testName = "special";
		expectProduct(16'h7e00, 16'h3c00, QNAN, 5'b10001);
		expectProduct(16'h3c00, 16'h7c01, QNAN, 5'b10001);
		expectProduct(16'h7c00, 16'h0000, QNAN, 5'b10000);
		expectProduct(16'h8000, 16'hfc00, QNAN, 5'b10000);
		expectProduct(16'h7c00, 16'h0001, QNAN, 5'b10000);  // Flushed subnormal is zero
		expectProduct(16'h7c00, 16'hc000, 16'hfc00, 5'b00000);
		expectProduct(16'hfc00, 16'hfc00, 16'h7c00, 5'b00000);
	endtask

	task automatic testRounding();
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] expRes;
		logic [FLAG_W-1:0] expFl;
		testName = "rounding";
		for (int i = 0; i < 200; i++) begin
			// Exponents 8..21 keep the product in range
			a = {1'($urandom), 5'(8 + $urandom % 14), 10'($urandom)};
			b = {1'($urandom), 5'(8 + $urandom % 14), 10'($urandom)};
			refMul(a, b, expRes, expFl);
			expectProduct(a, b, expRes, expFl);
		end
	endtask

	task automatic testQueue();
		logic [31:0] data;
		testName = "queue";
		for (int i = 0; i < QUEUE_DEPTH - 1; i++)
			launchPair(16'h3c00, 16'h4000 + 16'(i) * 16'h0200, 1'b0);  // 2, 3 and 4
		apbWrite(REG_OPB, 32'(16'h4000 + 16'(QUEUE_DEPTH - 1) * 16'h0200), 1'b0);
		apbWrite(REG_CMD, 32'h1, 1'b0);  // Takes the last free slot
		apbWrite(REG_CMD, 32'h1, 1'b1);  // Slot still held for the result in flight
		waitCount(QUEUE_DEPTH);
		expectStatus({2'b01, 4'(QUEUE_DEPTH)});
		apbWrite(REG_CMD, 32'h1, 1'b1);  // Queue full of stored results
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			popCheck(16'h4000 + 16'(i) * 16'h0200, 5'b00000);  // Launch order
			expectStatus({2'b00, 4'(QUEUE_DEPTH - 1 - i)});
		end
		apbRead(REG_RESULT, data, 1'b1);
		checkResult(16'h0, data[15:0]);
	endtask

	initial begin
		clk      = 1'b0;
		rst      = 1'b1;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		testName = "reset";
		void'($urandom(32'hcb77));
		applyReset();
		testBusErrors();
		testExact();
		testRange();
		testSpecial();
		testRounding();
		testQueue();
		if (dut.chk.failures == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			stopRun("Bound assertion failed before the end of the run");
		end
	end

endmodule

// File: test/fp16MulUnit_checker.sv
`timescale 1ns/1ns

module fp16MulUnit_checker import fp16Pkg::*; #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic                         clk,
	input logic                         rst,
	input logic                         psel,
	input logic                         penable,
	input logic                         pready,
	input apbState_t                    apbState,  // Phase seen by the control FSM
	input logic                         launch,
	input logic                         resValid,
	input logic [$clog2(QUEUE_DEPTH):0] count,
	input logic [$clog2(QUEUE_DEPTH):0] inFlight
);

	localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

	int failures = 0;  // Assertion failure count

	// Zero wait states
	assert property (@(posedge clk) disable iff (rst) pready)
		else begin
			failures++;
			$error("pready low");
		end

	// Access phase only right after a setup phase
	assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> apbState == APB_SETUP)
		else begin
			failures++;
			$error("APB access without setup");
		end

	// Two pipeline stages without stall
	assert property (@(posedge clk) disable iff (rst) resValid == $past(launch, 2))
		else begin
			failures++;
			$error("resValid not 2 cycles after launch");
		end

	assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(QUEUE_DEPTH))
		else begin
			failures++;
			$error("Queue count above depth");
		end

	// Reservation keeps a slot for every launch
	assert property (@(posedge clk) disable iff (rst)
		(CNT_W + 1)'(count) + (CNT_W + 1)'(inFlight) <= (CNT_W + 1)'(QUEUE_DEPTH))
		else begin
			failures++;
			$error("Stored plus in flight above depth");
		end

endmodule

bind fp16MulUnit fp16MulUnit_checker #(
	.QUEUE_DEPTH(QUEUE_DEPTH)
) chk (
	.clk      (clk),
	.rst      (rst),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.apbState (ctrl.apbState),
	.launch   (launch),
	.resValid (resValid),
	.count    (ctrl.count),
	.inFlight (ctrl.inFlight)
);
